/* rtl/tune_pkg.sv */
`default_nettype none

package tune_pkg;

    // recorder mode, shared by the controller and the top level
    typedef enum logic [1:0] {
        MODE_IDLE   = 2'd0,
        MODE_RECORD = 2'd1,
        MODE_PLAY   = 2'd2
    } mode_e;

    // width of one note code
    localparam int NOTE_WIDTH_DEFAULT = 8;

    // notes held by a single slot
    localparam int SLOT_DEPTH_DEFAULT = 16;

    // total slots, presets included
    localparam int NUM_SLOTS_DEFAULT = 9;

    // the lowest slots are fixed preset tunes
    localparam int PRESET_COUNT_DEFAULT = 5;

endpackage

`default_nettype wire

/* rtl/recorder_ctrl.sv */
`default_nettype none
`timescale 1ns/1ns

module recorder_ctrl (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             rec_btn,
    input  wire             stop_btn,
    input  wire             cancel_btn,
    input  wire             play_btn,
    input  wire             note_strobe,
    input  wire             note_tick,
    input  wire             note_valid,   // from the selected slot
    output tune_pkg::mode_e mode,
    output logic            write_en,
    output logic            read_en,
    output logic            read_rst,
    output logic            save,
    output logic            discard
);

    logic in_record;
    logic in_play;

    assign in_record = (mode == tune_pkg::MODE_RECORD);
    assign in_play   = (mode == tune_pkg::MODE_PLAY);

    // notes only reach the bank while recording
    assign write_en = note_strobe & in_record;

    // the first play cycle rewinds the pointer, so ticks are held off there
    assign read_en = note_tick & in_play & ~read_rst;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode     <= tune_pkg::MODE_IDLE;
            save     <= 1'b0;
            discard  <= 1'b0;
            read_rst <= 1'b0;
        end else begin
            save     <= 1'b0;                            // all strobes last one cycle
            discard  <= 1'b0;
            read_rst <= 1'b0;
            case (mode)
                tune_pkg::MODE_IDLE: begin
                    if (rec_btn) begin
                        mode <= tune_pkg::MODE_RECORD;
                    end else if (play_btn) begin
                        mode     <= tune_pkg::MODE_PLAY;
                        read_rst <= 1'b1;
                    end
                end
                tune_pkg::MODE_RECORD: begin
                    if (stop_btn) begin
                        mode <= tune_pkg::MODE_IDLE;
                        save <= 1'b1;                    // keep the tune
                    end else if (cancel_btn) begin
                        mode    <= tune_pkg::MODE_IDLE;
                        discard <= 1'b1;                 // throw the take away
                    end
                end
                tune_pkg::MODE_PLAY: begin
                    // note_valid still shows the old pointer during read_rst
                    if (!read_rst && (stop_btn || !note_valid)) begin
                        mode <= tune_pkg::MODE_IDLE;
                    end
                end
                default: begin
                    mode <= tune_pkg::MODE_IDLE;
                end
            endcase
        end
    end

    // a take is either kept or dropped, never both
    a_save_discard_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(save && discard)
    ) else $error("save and discard asserted together");

endmodule

`default_nettype wire

/* rtl/note_slot.sv */
`default_nettype none
`timescale 1ns/1ns

module note_slot #(
    parameter int   NOTE_WIDTH = tune_pkg::NOTE_WIDTH_DEFAULT,
    parameter int   SLOT_DEPTH = tune_pkg::SLOT_DEPTH_DEFAULT,
    localparam int  LEN_W      = $clog2(SLOT_DEPTH + 1)
) (
    input  wire                   clk,
    input  wire                   rst_n,        // per-slot clear from the bank
    input  wire                   write_en,
    input  wire                   read_en,
    input  wire                   read_rst,
    input  wire  [NOTE_WIDTH-1:0] note_in,
    output logic [NOTE_WIDTH-1:0] note_out,
    output logic                  note_valid,
    output logic [LEN_W-1:0]      tune_length
);

    localparam int ADDR_W = (SLOT_DEPTH > 1) ? $clog2(SLOT_DEPTH) : 1;
    localparam logic [LEN_W-1:0] DEPTH_L = LEN_W'(SLOT_DEPTH);

    logic [NOTE_WIDTH-1:0] notes [SLOT_DEPTH];
    logic [LEN_W-1:0]      rd_ptr;
    logic                  slot_full;

    assign slot_full = (tune_length == DEPTH_L);

    // the memory keeps stale notes after a clear, the length hides them
    always_ff @(posedge clk) begin
        if (rst_n && write_en && !slot_full) begin
            notes[tune_length[ADDR_W-1:0]] <= note_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tune_length <= '0;
        end else if (write_en && !slot_full) begin
            tune_length <= tune_length + 1'b1;           // extra notes are dropped
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (read_rst) begin
            rd_ptr <= '0;
        end else if (read_en && note_valid) begin
            rd_ptr <= rd_ptr + 1'b1;                     // parks one past the last note
        end
    end

    assign note_valid = (rd_ptr < tune_length);

    // past the end the index wraps, but note_valid is low there anyway
    assign note_out = notes[rd_ptr[ADDR_W-1:0]];

    a_length_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        tune_length <= DEPTH_L
    ) else $error("tune length %0d beyond slot depth", tune_length);

endmodule

`default_nettype wire

/* rtl/preset_slot.sv */
`default_nettype none
`timescale 1ns/1ns

module preset_slot #(
    parameter int   NOTE_WIDTH = tune_pkg::NOTE_WIDTH_DEFAULT,
    parameter int   SLOT_DEPTH = tune_pkg::SLOT_DEPTH_DEFAULT,
    parameter int   PRESET_ID  = 0,
    localparam int  LEN_W      = $clog2(SLOT_DEPTH + 1)
) (
    input  wire                   clk,
    input  wire                   rst_n,       // only rewinds, the tune is fixed
    input  wire                   read_en,
    input  wire                   read_rst,
    output logic [NOTE_WIDTH-1:0] note_out,
    output logic                  note_valid,
    output logic [LEN_W-1:0]      tune_length
);

    localparam int TUNE_LEN  = PRESET_ID + 4;
    localparam int BASE_NOTE = 16 * (PRESET_ID + 1);

    logic [LEN_W-1:0] rd_ptr;

    // each preset climbs upward from its own base note
    function automatic logic [NOTE_WIDTH-1:0] preset_note(input logic [LEN_W-1:0] idx);
        int code;
        code = BASE_NOTE + int'(idx);
        return NOTE_WIDTH'(code);
    endfunction

    if (TUNE_LEN > SLOT_DEPTH) begin : g_len_check
        $error("preset %0d needs %0d notes, slot depth is %0d",
               PRESET_ID, TUNE_LEN, SLOT_DEPTH);
    end

    assign tune_length = LEN_W'(TUNE_LEN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (read_rst) begin
            rd_ptr <= '0;
        end else if (read_en && note_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign note_valid = (rd_ptr < tune_length);
    assign note_out   = preset_note(rd_ptr);

endmodule

`default_nettype wire

/* rtl/slot_bank.sv */
`default_nettype none
`timescale 1ns/1ns

module slot_bank #(
    parameter int   NOTE_WIDTH   = tune_pkg::NOTE_WIDTH_DEFAULT,
    parameter int   SLOT_DEPTH   = tune_pkg::SLOT_DEPTH_DEFAULT,
    parameter int   NUM_SLOTS    = tune_pkg::NUM_SLOTS_DEFAULT,
    parameter int   PRESET_COUNT = tune_pkg::PRESET_COUNT_DEFAULT,
    localparam int  IDX_W        = $clog2(NUM_SLOTS),
    localparam int  LEN_W        = $clog2(SLOT_DEPTH + 1)
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   write_en,
    input  wire                   read_en,
    input  wire                   read_rst,
    input  wire                   save,
    input  wire                   discard,
    input  wire                   delete_btn,
    input  wire  [IDX_W-1:0]      select,
    input  wire  [NOTE_WIDTH-1:0] note_in,
    output logic [NOTE_WIDTH-1:0] note_out,
    output logic                  note_valid,
    output logic [LEN_W-1:0]      tune_length,
    output logic [NUM_SLOTS-1:0]  slot_status,
    output logic [IDX_W-1:0]      next_slot,
    output logic [IDX_W-1:0]      saved_count,
    output logic                  full_flag
);

    localparam logic [IDX_W-1:0]     FIRST_REC   = IDX_W'(PRESET_COUNT);
    localparam logic [IDX_W-1:0]     LAST_REC    = IDX_W'(NUM_SLOTS - 1);
    localparam logic [IDX_W-1:0]     COUNT_MAX   = IDX_W'(NUM_SLOTS - PRESET_COUNT - 1);
    localparam logic [NUM_SLOTS-1:0] PRESET_MASK = {NUM_SLOTS{1'b1}} >> (NUM_SLOTS - PRESET_COUNT);

    logic [NOTE_WIDTH-1:0] slot_note  [NUM_SLOTS];
    logic                  slot_valid [NUM_SLOTS];
    logic [LEN_W-1:0]      slot_len   [NUM_SLOTS];
    logic [IDX_W-1:0]      next_wrap;
    logic                  sel_ok;
    logic                  sel_rec;

    // the ring only walks the recordable slots
    assign next_wrap = (next_slot == LAST_REC) ? FIRST_REC : next_slot + 1'b1;

    assign sel_ok  = (select <= LAST_REC);
    assign sel_rec = sel_ok && (select >= FIRST_REC);

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        // save empties the slot the ring moves onto, discard the one in use
        wire clr_n = rst_n
                   & ~(save && next_wrap == IDX_W'(i))
                   & ~(discard && next_slot == IDX_W'(i))
                   & ~(delete_btn && select == IDX_W'(i));

        if (i < PRESET_COUNT) begin : g_preset
            preset_slot #(
                .NOTE_WIDTH (NOTE_WIDTH),
                .SLOT_DEPTH (SLOT_DEPTH),
                .PRESET_ID  (i)
            ) u_preset (
                .clk         (clk),
                .rst_n       (clr_n),
                .read_en     (read_en),
                .read_rst    (read_rst),
                .note_out    (slot_note[i]),
                .note_valid  (slot_valid[i]),
                .tune_length (slot_len[i])
            );
        end else begin : g_rec
            wire slot_we = write_en && (next_slot == IDX_W'(i));

            note_slot #(
                .NOTE_WIDTH (NOTE_WIDTH),
                .SLOT_DEPTH (SLOT_DEPTH)
            ) u_note (
                .clk         (clk),
                .rst_n       (clr_n),
                .write_en    (slot_we),
                .read_en     (read_en),
                .read_rst    (read_rst),
                .note_in     (note_in),
                .note_out    (slot_note[i]),
                .note_valid  (slot_valid[i]),
                .tune_length (slot_len[i])
            );
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_slot   <= FIRST_REC;
            saved_count <= '0;
            slot_status <= PRESET_MASK;
        end else begin
            if (save) begin
                slot_status[next_slot] <= 1'b1;
                slot_status[next_wrap] <= 1'b0;          // about to be overwritten
                next_slot              <= next_wrap;
                if (!full_flag) begin
                    saved_count <= saved_count + 1'b1;
                end
            end
            // presets keep their mark since their tune survives a delete
            if (delete_btn && sel_rec) begin
                slot_status[select] <= 1'b0;
            end
        end
    end

    assign full_flag = (saved_count == COUNT_MAX);

    // an index past the last slot reads as an empty tune
    assign note_out    = sel_ok ? slot_note[select]  : '0;
    assign note_valid  = sel_ok ? slot_valid[select] : 1'b0;
    assign tune_length = sel_ok ? slot_len[select]   : '0;

    a_next_in_ring: assert property (
        @(posedge clk) disable iff (!rst_n)
        next_slot >= FIRST_REC && next_slot <= LAST_REC
    ) else $error("next slot %0d left the recordable ring", next_slot);

endmodule

`default_nettype wire

/* rtl/tune_recorder_top.sv */
`default_nettype none
`timescale 1ns/1ns

module tune_recorder_top #(
    parameter int   NOTE_WIDTH   = tune_pkg::NOTE_WIDTH_DEFAULT,
    parameter int   SLOT_DEPTH   = tune_pkg::SLOT_DEPTH_DEFAULT,
    parameter int   NUM_SLOTS    = tune_pkg::NUM_SLOTS_DEFAULT,
    parameter int   PRESET_COUNT = tune_pkg::PRESET_COUNT_DEFAULT,
    localparam int  IDX_W        = $clog2(NUM_SLOTS),
    localparam int  LEN_W        = $clog2(SLOT_DEPTH + 1)
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   rec_btn,
    input  wire                   stop_btn,
    input  wire                   cancel_btn,
    input  wire                   play_btn,
    input  wire                   delete_btn,
    input  wire                   note_strobe,
    input  wire  [NOTE_WIDTH-1:0] note_in,
    input  wire                   note_tick,     // playback pace, one note per tick
    input  wire  [IDX_W-1:0]      select,
    output tune_pkg::mode_e       mode,
    output logic [NOTE_WIDTH-1:0] note_out,
    output logic                  note_valid,
    output logic [LEN_W-1:0]      tune_length,
    output logic [NUM_SLOTS-1:0]  slot_status,
    output logic [IDX_W-1:0]      next_slot,
    output logic [IDX_W-1:0]      saved_count,
    output logic                  full_flag
);

    logic write_en;
    logic read_en;
    logic read_rst;
    logic save;
    logic discard;

    recorder_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .rec_btn     (rec_btn),
        .stop_btn    (stop_btn),
        .cancel_btn  (cancel_btn),
        .play_btn    (play_btn),
        .note_strobe (note_strobe),
        .note_tick   (note_tick),
        .note_valid  (note_valid),
        .mode        (mode),
        .write_en    (write_en),
        .read_en     (read_en),
        .read_rst    (read_rst),
        .save        (save),
        .discard     (discard)
    );

    slot_bank #(
        .NOTE_WIDTH   (NOTE_WIDTH),
        .SLOT_DEPTH   (SLOT_DEPTH),
        .NUM_SLOTS    (NUM_SLOTS),
        .PRESET_COUNT (PRESET_COUNT)
    ) u_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_en    (write_en),
        .read_en     (read_en),
        .read_rst    (read_rst),
        .save        (save),
        .discard     (discard),
        .delete_btn  (delete_btn),
        .select      (select),
        .note_in     (note_in),
        .note_out    (note_out),
        .note_valid  (note_valid),
        .tune_length (tune_length),
        .slot_status (slot_status),
        .next_slot   (next_slot),
        .saved_count (saved_count),
        .full_flag   (full_flag)
    );

endmodule

`default_nettype wire

/* verification/tune_recorder_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module tune_recorder_tb;

    localparam int DEPTH     = 16;
    localparam int NUM_SLOTS = 9;
    localparam int FIRST_REC = 5;
    localparam int LAST_REC  = 8;
    localparam int NUM_STEPS = 21;
    localparam int SLACK     = 40;                   // cycles per step beyond its notes

    localparam int OP_SAVE   = 0;
    localparam int OP_CANCEL = 1;
    localparam int OP_PLAY   = 2;
    localparam int OP_DELETE = 3;

    localparam int C_OP     = 0;
    localparam int C_SEL    = 1;
    localparam int C_COUNT  = 2;
    localparam int C_BASE   = 3;
    localparam int C_STATUS = 4;
    localparam int C_NEXT   = 5;
    localparam int C_SAVED  = 6;
    localparam int C_FULL   = 7;

    // op, slot, notes, base note, then slot_status, next_slot, saved_count, full_flag after it
    localparam int STEPS [NUM_STEPS][8] = '{
        '{OP_PLAY,   0,  0, 'h00, 'h01f, 5, 0, 0},
        '{OP_PLAY,   1,  0, 'h00, 'h01f, 5, 0, 0},
        '{OP_PLAY,   2,  0, 'h00, 'h01f, 5, 0, 0},
        '{OP_PLAY,   3,  0, 'h00, 'h01f, 5, 0, 0},
        '{OP_PLAY,   4,  0, 'h00, 'h01f, 5, 0, 0},
        '{OP_SAVE,   5,  5, 'h40, 'h03f, 6, 1, 0},
        '{OP_PLAY,   5,  0, 'h00, 'h03f, 6, 1, 0},
        '{OP_CANCEL, 6,  3, 'h80, 'h03f, 6, 1, 0},
        '{OP_PLAY,   6,  0, 'h00, 'h03f, 6, 1, 0},
        '{OP_SAVE,   6, 16, 'h10, 'h07f, 7, 2, 0},
        '{OP_SAVE,   7, 18, 'h20, 'h0ff, 8, 3, 1},   // two notes past the slot depth
        '{OP_PLAY,   7,  0, 'h00, 'h0ff, 8, 3, 1},
        '{OP_SAVE,   8,  4, 'hc0, 'h1df, 5, 3, 1},   // ring wraps onto slot 5
        '{OP_PLAY,   5,  0, 'h00, 'h1df, 5, 3, 1},
        '{OP_PLAY,   8,  0, 'h00, 'h1df, 5, 3, 1},
        '{OP_DELETE, 6,  0, 'h00, 'h19f, 5, 3, 1},
        '{OP_PLAY,   6,  0, 'h00, 'h19f, 5, 3, 1},
        '{OP_DELETE, 2,  0, 'h00, 'h19f, 5, 3, 1},
        '{OP_PLAY,   2,  0, 'h00, 'h19f, 5, 3, 1},
        '{OP_SAVE,   5,  2, 'he0, 'h1bf, 6, 3, 1},
        '{OP_PLAY,   5,  0, 'h00, 'h1bf, 6, 3, 1}
    };

    logic            clk;
    logic            rst_n;
    logic            rec_btn;
    logic            stop_btn;
    logic            cancel_btn;
    logic            play_btn;
    logic            delete_btn;
    logic            note_strobe;
    logic [7:0]      note_in;
    logic            note_tick;
    logic [3:0]      select;
    tune_pkg::mode_e mode;
    logic [7:0]      note_out;
    logic            note_valid;
    logic [4:0]      tune_length;
    logic [8:0]      slot_status;
    logic [3:0]      next_slot;
    logic [3:0]      saved_count;
    logic            full_flag;

    int exp_notes [NUM_SLOTS][DEPTH];                // reference copy of every slot
    int exp_len   [NUM_SLOTS];
    int ring_next;
    int errors       = 0;
    int failed_tests = 0;
    int cycles       = 0;
    int cycle_limit  = 1000;

    tune_recorder_top dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic compare_hex(input int step, input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] test %0d %s: got 0x%0h, expected 0x%0h", step, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_state(input int step, input int status, input int next,
                               input int saved, input int full);
        compare_hex(step, "mode", int'(mode), int'(tune_pkg::MODE_IDLE));
        compare_hex(step, "slot_status", int'(slot_status), status);
        compare_hex(step, "next_slot", int'(next_slot), next);
        compare_hex(step, "saved_count", int'(saved_count), saved);
        compare_hex(step, "full_flag", int'(full_flag), full);
    endtask

    task automatic record_tune(input int step, input int n, input int base, input bit keep);
        int slot;
        int v;
        int wrap;
        slot    = ring_next;
        rec_btn = 1'b1;
        @(negedge clk);
        rec_btn = 1'b0;
        compare_hex(step, "mode", int'(mode), int'(tune_pkg::MODE_RECORD));
        for (int i = 0; i < n; i++) begin
            v           = (base + int'($urandom() % 16)) % 256;
            note_in     = 8'(v);
            note_strobe = 1'b1;
            if (exp_len[slot] < DEPTH) begin         // a full slot drops the rest
                exp_notes[slot][exp_len[slot]] = v;
                exp_len[slot]++;
            end
            @(negedge clk);
        end
        note_strobe = 1'b0;
        stop_btn    = keep;
        cancel_btn  = !keep;
        @(negedge clk);
        stop_btn   = 1'b0;
        cancel_btn = 1'b0;
        @(negedge clk);                              // the save or discard strobe acted here
        if (keep) begin
            wrap          = (ring_next == LAST_REC) ? FIRST_REC : ring_next + 1;
            exp_len[wrap] = 0;
            ring_next     = wrap;
        end else begin
            exp_len[slot] = 0;
        end
    endtask

    task automatic play_slot(input int step, input int s);
        int idx;
        idx      = 0;
        select   = 4'(s);
        play_btn = 1'b1;
        @(negedge clk);
        play_btn = 1'b0;
        compare_hex(step, "mode", int'(mode), int'(tune_pkg::MODE_PLAY));
        @(negedge clk);                              // read pointer is back at 0 now
        compare_hex(step, "tune_length", int'(tune_length), exp_len[s]);
        while (mode == tune_pkg::MODE_PLAY) begin
            if (note_valid) begin
                if (idx < exp_len[s]) begin
                    compare_hex(step, "note_out", int'(note_out), exp_notes[s][idx]);
                end else begin
                    compare_hex(step, "note_valid", 1, 0);
                end
                idx++;
                note_tick = 1'b1;
            end else begin
                note_tick = 1'b0;
            end
            @(negedge clk);
        end
        note_tick = 1'b0;
        compare_hex(step, "notes played", idx, exp_len[s]);
    endtask

    task automatic delete_slot(input int s);
        select     = 4'(s);
        delete_btn = 1'b1;
        @(negedge clk);
        delete_btn = 1'b0;
        if (s >= FIRST_REC) begin
            exp_len[s] = 0;                          // a preset tune cannot be erased
        end
    endtask

    initial begin
        int errors_before;
        void'($urandom(32'h3e77_949b));
        clk         = 1'b0;
        rst_n       = 1'b0;
        rec_btn     = 1'b0;
        stop_btn    = 1'b0;
        cancel_btn  = 1'b0;
        play_btn    = 1'b0;
        delete_btn  = 1'b0;
        note_strobe = 1'b0;
        note_in     = '0;
        note_tick   = 1'b0;
        select      = '0;
        cycle_limit = 20;
        for (int k = 0; k < NUM_STEPS; k++) begin
            cycle_limit += STEPS[k][C_COUNT] + SLACK;
        end
        // preset k holds k+4 notes climbing from 16*(k+1)
        for (int k = 0; k < NUM_SLOTS; k++) begin
            exp_len[k] = (k < FIRST_REC) ? k + 4 : 0;
            for (int i = 0; i < DEPTH; i++) begin
                exp_notes[k][i] = 16 * (k + 1) + i;
            end
        end
        ring_next = FIRST_REC;

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_state(0, 'h01f, FIRST_REC, 0, 0);
        if (errors != 0) begin
            failed_tests++;
        end
        $display("test 0 reset state: %s", (errors == 0) ? "ok" : "mismatch");

        for (int k = 0; k < NUM_STEPS; k++) begin
            errors_before = errors;
            case (STEPS[k][C_OP])
                OP_SAVE:   record_tune(k + 1, STEPS[k][C_COUNT], STEPS[k][C_BASE], 1'b1);
                OP_CANCEL: record_tune(k + 1, STEPS[k][C_COUNT], STEPS[k][C_BASE], 1'b0);
                OP_PLAY:   play_slot(k + 1, STEPS[k][C_SEL]);
                default:   delete_slot(STEPS[k][C_SEL]);
            endcase
            check_state(k + 1, STEPS[k][C_STATUS], STEPS[k][C_NEXT],
                        STEPS[k][C_SAVED], STEPS[k][C_FULL]);
            if (errors != errors_before) begin
                failed_tests++;
            end
            $display("test %0d op %0d slot %0d: %s", k + 1, STEPS[k][C_OP], STEPS[k][C_SEL],
                     (errors == errors_before) ? "ok" : "mismatch");
        end

        $display("%0d tests run, %0d with mismatches, %0d check errors",
                 NUM_STEPS + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tune_recorder.f */
rtl/tune_pkg.sv
rtl/recorder_ctrl.sv
rtl/note_slot.sv
rtl/preset_slot.sv
rtl/slot_bank.sv
rtl/tune_recorder_top.sv
verification/tune_recorder_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tune_recorder_tb \
    -f tune_recorder.f \
    -o sim_tune_recorder

output=$(./obj_dir/sim_tune_recorder)
echo "$output"

if grep -qx "=== PASS ===" <<< "$output"; then
    exit 0
else
    exit 1
fi
